//--- cdcFifo/cdcFifo.sv
// **************************************************
// Dual-clock FIFO top level, ready/valid on both sides.
// Push and pop clocks may be fully unrelated.
// **************************************************
`timescale 1ns/1ps
`include "cdcFifo_macros.svh"

module cdcFifo (
  input  logic              pushClk,
  input  logic              popClk,
  input  logic              rstN,
  input  logic              pushValid,
  input  cdcFifoPkg::dataT  pushData,
  output logic              pushReady,
  output logic              pushFull,
  output cdcFifoPkg::countT pushSlots,
  input  logic              popReady,
  output logic              popValid,
  output cdcFifoPkg::dataT  popData,
  output logic              popEmpty,
  output cdcFifoPkg::countT popItems
);
  import cdcFifoPkg::*;

  // Pointer crossings.
  // Gray copies leave their home domain and come back as binary.
  ptrT wrPtrGray;
  ptrT wrPtrSync;
  ptrT poppedPtrGray;
  ptrT rdPtrSync;

  fifoRamIf ramIf ();

  pushCtrl uPushCtrl (
    .pushClk  (pushClk),
    .rstN     (rstN),
    .pushValid(pushValid),
    .pushData (pushData),
    .pushReady(pushReady),
    .pushFull (pushFull),
    .pushSlots(pushSlots),
    .rdPtrSync(rdPtrSync),
    .wrPtrGray(wrPtrGray),
    .ram      (ramIf.writer)
  );

  popCtrl uPopCtrl (
    .popClk       (popClk),
    .rstN         (rstN),
    .popReady     (popReady),
    .popValid     (popValid),
    .popData      (popData),
    .popEmpty     (popEmpty),
    .popItems     (popItems),
    .wrPtrSync    (wrPtrSync),
    .poppedPtrGray(poppedPtrGray),
    .ram          (ramIf.reader)
  );

  // The RAM is written from the push side, so it runs on pushClk.
  flopRam uFlopRam (
    .clk(pushClk),
    .ram(ramIf.ram)
  );

  // Write pointer into the pop domain.
  grayPtrSync #(.Stages(`CDC_FIFO_SYNC_STAGES)) uWrPtrSync (
    .clk    (popClk),
    .rstN   (rstN),
    .ptrGray(wrPtrGray),
    .ptrBin (wrPtrSync)
  );

  // Popped pointer into the push domain.
  grayPtrSync #(.Stages(`CDC_FIFO_SYNC_STAGES)) uRdPtrSync (
    .clk    (pushClk),
    .rstN   (rstN),
    .ptrGray(poppedPtrGray),
    .ptrBin (rdPtrSync)
  );

endmodule

//--- cdcFifo/flopRam.sv
// **************************************************
// Flop storage for the FIFO.
// Synchronous write, combinational read.
// **************************************************
`timescale 1ns/1ps

module flopRam (
  input logic   clk,
  fifoRamIf.ram ram
);
  import cdcFifoPkg::*;

  // One word per FIFO entry.
  dataT mem [DepthC];

  // Writes land in the push domain, one word per edge.
  always_ff @(posedge clk) begin
    if (ram.wrEn) begin
      mem[ram.wrAddr] <= ram.wrData;
    end
  end

  // The read side sits in the other domain and samples this path with its own clock.
  // The pointer protocol keeps any entry stable while it is being read.
  assign ram.rdData = mem[ram.rdAddr];

endmodule

//--- cdcFifo/grayPtrSync.sv
// **************************************************
// Brings a Gray pointer into another clock domain.
// The result comes out in binary after Stages edges.
// **************************************************
`timescale 1ns/1ps
`include "cdcFifo_macros.svh"

module grayPtrSync #(
  parameter int Stages = `CDC_FIFO_SYNC_STAGES
) (
  input  logic             clk,
  input  logic             rstN,
  input  cdcFifoPkg::ptrT  ptrGray,
  output cdcFifoPkg::ptrT  ptrBin
);
  import cdcFifoPkg::*;

  // Synchronizer chain.
  // Only stage 0 samples the foreign domain and may go metastable.
  ptrT syncQ [Stages];

  // The source publishes its pointer from a register, one bit flip per move.
  // Any sample therefore lands on either the old or the new value.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < Stages; i++) begin
        syncQ[i] <= '0;
      end
    end else begin
      syncQ[0] <= ptrGray;
      for (int i = 1; i < Stages; i++) begin
        syncQ[i] <= syncQ[i-1];
      end
    end
  end

  // Decode only after the last stage, so the decoder never sees an unsettled value.
  assign ptrBin = gray2Bin(syncQ[Stages-1]);

  // The source may step more than once between two of our edges.
  // The decoded pointer must still only move forward, and never by more
  // than a full FIFO of entries.
  // A larger jump means a multi-bit Gray change was sampled mid-flight.
  synchronizedPtrStepBounded: assert property (
    @(posedge clk) disable iff (!rstN)
    ptrT'(ptrBin - $past(ptrBin)) <= ptrT'(DepthC)
  ) else $error("grayPtrSync: synchronized pointer jumped from %0d to %0d",
                $past(ptrBin), ptrBin);

endmodule

//--- cdcFifo/popCtrl.sv
// **************************************************
// Pop-side control: fetch from RAM into a registered output.
// Publishes the popped pointer back to the push side.
// **************************************************
`timescale 1ns/1ps

module popCtrl (
  input  logic              popClk,
  input  logic              rstN,
  input  logic              popReady,
  output logic              popValid,
  output cdcFifoPkg::dataT  popData,
  output logic              popEmpty,
  output cdcFifoPkg::countT popItems,
  input  cdcFifoPkg::ptrT   wrPtrSync,
  output cdcFifoPkg::ptrT   poppedPtrGray,
  fifoRamIf.reader          ram
);
  import cdcFifoPkg::*;

  // Two read pointers.
  // fetchPtr marks the next word to move into the output register.
  // poppedPtr marks the next word to leave through the handshake.
  // They differ by one while the output register holds a word.
  ptrT  fetchPtr;
  ptrT  poppedPtr;
  ptrT  poppedNext;
  logic outValid;
  dataT outData;
  logic popFire;
  logic wordAvail;
  logic loadEn;

  assign popFire   = outValid && popReady;
  assign wordAvail = (fetchPtr != wrPtrSync);

  // Refill when the register is empty or is being emptied this edge.
  assign loadEn = wordAvail && (!outValid || popReady);

  assign ram.rdAddr = addrT'(fetchPtr);
  assign poppedNext = poppedPtr + ptrT'(1);

  always_ff @(posedge popClk or negedge rstN) begin
    if (!rstN) begin
      fetchPtr      <= '0;
      poppedPtr     <= '0;
      poppedPtrGray <= '0;
      outValid      <= 1'b0;
    end else begin
      if (loadEn) begin
        fetchPtr <= fetchPtr + ptrT'(1);
      end
      // A slot is returned to the writer only once its word has left.
      // Freeing it on fetch would let a push overwrite the held word's source.
      if (popFire) begin
        poppedPtr     <= poppedNext;
        poppedPtrGray <= bin2Gray(poppedNext);
      end
      if (loadEn) begin
        outValid <= 1'b1;
      end else if (popFire) begin
        outValid <= 1'b0;
      end
    end
  end

  // Output word register.
  always_ff @(posedge popClk) begin
    if (loadEn) begin
      outData <= ram.rdData;
    end
  end

  assign popValid = outValid;
  assign popData  = outData;

  // Occupancy counts the word in the output register too.
  assign popItems = countT'(wrPtrSync - poppedPtr);
  assign popEmpty = (popItems == '0);

  // A stalled word must hold until it is taken.
  popOutputStable: assert property (
    @(posedge popClk) disable iff (!rstN)
    (popValid && !popReady) |=> (popValid && $stable(popData))
  ) else $error("pop output changed while stalled");

endmodule

//--- cdcFifo/pushCtrl.sv
// **************************************************
// Push-side control: write pointer, full flag, free slots.
// Runs entirely in the push clock domain.
// **************************************************
`timescale 1ns/1ps

module pushCtrl (
  input  logic              pushClk,
  input  logic              rstN,
  input  logic              pushValid,
  input  cdcFifoPkg::dataT  pushData,
  output logic              pushReady,
  output logic              pushFull,
  output cdcFifoPkg::countT pushSlots,
  input  cdcFifoPkg::ptrT   rdPtrSync,
  output cdcFifoPkg::ptrT   wrPtrGray,
  fifoRamIf.writer          ram
);
  import cdcFifoPkg::*;

  ptrT  wrPtr;
  ptrT  wrPtrNext;
  ptrT  usedEntries;
  logic pushFire;

  // Entries still held by the FIFO as this side sees them.
  // rdPtrSync lags the real popped pointer, so this is pessimistic and safe.
  assign usedEntries = wrPtr - rdPtrSync;
  assign pushSlots   = DepthC - countT'(usedEntries);

  assign pushFull  = (pushSlots == '0);
  assign pushReady = !pushFull;
  assign pushFire  = pushValid && pushReady;

  assign wrPtrNext = wrPtr + ptrT'(1);

  // An accepted word goes straight into the RAM at the accepting edge.
  // Only the low bits of the pointer address the array.
  assign ram.wrEn   = pushFire;
  assign ram.wrAddr = addrT'(wrPtr);
  assign ram.wrData = pushData;

  // The Gray copy is a register of its own.
  // The pop domain must never sample a combinational decode glitch.
  always_ff @(posedge pushClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr     <= '0;
      wrPtrGray <= '0;
    end else if (pushFire) begin
      wrPtr     <= wrPtrNext;
      wrPtrGray <= bin2Gray(wrPtrNext);
    end
  end

  // A write into a slot still held by the pop side would overwrite an unread word.
  // The held count is taken straight from the pointers, not from the flags.
  noWriteWhenFull: assert property (
    @(posedge pushClk) disable iff (!rstN)
    ram.wrEn |-> (usedEntries < ptrT'(DepthC))
  ) else $error("pushCtrl: RAM write issued while FIFO is full");

  // The synchronized read pointer may never pass the write pointer.
  // If it did, the slot count would wrap above the depth.
  slotsWithinDepth: assert property (
    @(posedge pushClk) disable iff (!rstN)
    pushSlots <= DepthC
  ) else $error("pushCtrl: pushSlots %0d exceeds depth", pushSlots);

endmodule

//--- common/cdcFifoPkg.sv
// **************************************************
// Shared types and Gray helpers for the dual-clock FIFO.
// **************************************************
package cdcFifoPkg;
  `include "cdcFifo_macros.svh"

  // Derived widths.
  // A count must be able to hold the depth itself, hence the +1.
  localparam int AddrW  = $clog2(`CDC_FIFO_DEPTH);
  localparam int CountW = $clog2(`CDC_FIFO_DEPTH + 1);

  typedef logic [`CDC_FIFO_WIDTH-1:0] dataT;
  typedef logic [AddrW-1:0]           addrT;
  // The extra top bit tells a full FIFO from an empty one.
  typedef logic [AddrW:0]             ptrT;
  typedef logic [CountW-1:0]          countT;

  localparam countT DepthC = countT'(`CDC_FIFO_DEPTH);

  // Binary to reflected Gray code.
  function automatic ptrT bin2Gray(ptrT b);
    return b ^ (b >> 1);
  endfunction

  // Reflected Gray code back to binary, one XOR ripple from the top bit.
  function automatic ptrT gray2Bin(ptrT g);
    ptrT b;
    b[$bits(ptrT)-1] = g[$bits(ptrT)-1];
    for (int i = $bits(ptrT) - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction
endpackage

//--- common/cdcFifo_macros.svh
// **************************************************
// Build-time sizing for the dual-clock FIFO.
// Include wherever depth, width or sync stages are needed.
// **************************************************
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// Number of FIFO entries.
// Keep this a power of two, at least 2, so the pointers wrap cleanly.
`define CDC_FIFO_DEPTH 8

// Payload width in bits.
`define CDC_FIFO_WIDTH 16

// Flops in each Gray pointer synchronizer, 2 or more.
`define CDC_FIFO_SYNC_STAGES 3

`endif

//--- common/fifoRamIf.sv
// **************************************************
// Write and read ports of the FIFO flop RAM.
// **************************************************
`timescale 1ns/1ps

interface fifoRamIf;
  import cdcFifoPkg::*;

  // Write port, owned by the push domain.
  logic wrEn;
  addrT wrAddr;
  dataT wrData;

  // Read port, owned by the pop domain.
  // Read data follows rdAddr without a clock.
  addrT rdAddr;
  dataT rdData;

  // The push controller issues writes.
  modport writer (
    output wrEn,
    output wrAddr,
    output wrData
  );

  // The pop controller addresses the array and takes the word back.
  modport reader (
    output rdAddr,
    input  rdData
  );

  // The storage array itself.
  modport ram (
    input  wrEn,
    input  wrAddr,
    input  wrData,
    input  rdAddr,
    output rdData
  );
endinterface

//--- tests/cdcFifoTb.sv
// **************************************************
// Testbench for the dual-clock FIFO: random traffic, fill and drain.
// Every popped word is compared against a reference queue.
// **************************************************
`timescale 1ns/1ps

module cdcFifoTb;
  import cdcFifoPkg::*;

  localparam int RandWords = 384;
  localparam int Depth = int'(DepthC);
  // Every transfer of the run gets eight periods of the slower clock.
  localparam int WatchNs = (RandWords + 2 * Depth) * 26 * 8;
  localparam logic [31:0] Seed = 32'h82fc_cfa4;

  logic pushClk = 1'b0;
  logic popClk = 1'b0;
  logic rstN;
  logic pushValid;
  dataT pushData;
  logic pushReady;
  logic pushFull;
  countT pushSlots;
  logic popReady;
  logic popValid;
  dataT popData;
  logic popEmpty;
  countT popItems;

  // Each domain steps its own LFSR, so the two clocks never race on one state.
  logic [31:0] pushRng;
  logic [31:0] popRng;
  dataT refQ[$];
  logic holdPending = 1'b0;
  dataT heldData;
  int accepted;

  cdcFifo DUT (.*);

  // Unrelated periods make the crossing real.
  always #10 pushClk = ~pushClk;
  always #13 popClk = ~popClk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
  function automatic logic [31:0] randBits(inout logic [31:0] state, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      state = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
      r = {r[30:0], state[0]};
    end
    return r;
  endfunction

  // Reference model.
  // The oldest accepted word not yet popped is the only legal output.
  function automatic dataT refPopHead();
    return refQ.pop_front();
  endfunction

  task automatic stopOnError();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkData(string name, dataT actual, dataT expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
      stopOnError();
    end
  endtask

  task automatic checkCount(string name, countT actual, countT expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      stopOnError();
    end
  endtask

  task automatic checkFlag(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
      stopOnError();
    end
  endtask

  // Push monitor feeds the reference queue and bounds the slot count.
  always @(posedge pushClk) begin
    if (rstN) begin
      if (pushValid && pushReady) begin
        refQ.push_back(pushData);
      end
      if (pushSlots > DepthC) begin
        $display("pushSlots rose to %0d, above the FIFO depth, at %0t", pushSlots, $time);
        stopOnError();
      end
    end
  end

  // Pop monitor checks order, integrity and that a stalled word holds.
  always @(posedge popClk) begin
    if (rstN) begin
      if (holdPending) begin
        checkFlag("popValid", popValid, 1'b1);
        checkData("popData", popData, heldData);
      end
      holdPending = popValid && !popReady;
      heldData = popData;
      if (popValid && popReady) begin
        if (refQ.size() == 0) begin
          $display("A word was popped at %0t while none was outstanding", $time);
          stopOnError();
        end
        checkData("popData", popData, refPopHead());
      end
    end
  end

  // Offers up to count words within maxCycles edges; valid and data hold while stalled.
  task automatic pushWords(int count, bit randomGaps, int maxCycles, output int sent);
    int cycles;
    sent = 0;
    cycles = 0;
    while (sent < count && cycles < maxCycles) begin
      @(posedge pushClk);
      cycles++;
      if (pushValid && pushReady) sent++;
      if ((!pushValid || pushReady) && sent < count) begin
        pushValid <= !randomGaps || (randBits(pushRng, 2) != 0);
        pushData <= dataT'(randBits(pushRng, $bits(dataT)));
      end
    end
    pushValid <= 1'b0;
  endtask

  task automatic popWords(int count, bit randomGaps);
    int got;
    got = 0;
    while (got < count) begin
      @(posedge popClk);
      if (popValid && popReady) got++;
      popReady <= !randomGaps || (randBits(popRng, 2) != 0);
    end
    popReady <= 1'b0;
  endtask

  task automatic checkDrained();
    repeat (10) @(posedge popClk);
    repeat (10) @(posedge pushClk);
    checkFlag("popEmpty", popEmpty, 1'b1);
    checkCount("popItems", popItems, '0);
    checkCount("pushSlots", pushSlots, DepthC);
    if (refQ.size() != 0) begin
      $display("%0d pushed words were never popped", refQ.size());
      stopOnError();
    end
  endtask

  initial begin
    rstN = 1'b0;
    pushValid = 1'b0;
    pushData = '0;
    popReady = 1'b0;
    pushRng = Seed;
    popRng = Seed;
    // Move the pop stream away from the push stream.
    void'(randBits(popRng, 32));
    repeat (2) @(posedge pushClk);
    rstN <= 1'b1;
    @(posedge pushClk);
    checkFlag("pushReady", pushReady, 1'b1);
    checkFlag("pushFull", pushFull, 1'b0);
    checkCount("pushSlots", pushSlots, DepthC);
    checkFlag("popValid", popValid, 1'b0);
    checkFlag("popEmpty", popEmpty, 1'b1);
    checkCount("popItems", popItems, '0);

    // Random gaps on both sides.
    fork
      pushWords(RandWords, 1'b1, 32'h7fff_ffff, accepted);
      popWords(RandWords, 1'b1);
    join
    checkDrained();

    // Fill against a stalled pop side; only DEPTH words may get in.
    pushWords(Depth + 4, 1'b0, 3 * Depth, accepted);
    if (accepted != Depth) begin
      $display("%0d pushes were accepted into a FIFO of depth %0d", accepted, Depth);
      stopOnError();
    end
    repeat (2) @(posedge pushClk);
    checkFlag("pushReady", pushReady, 1'b0);
    checkFlag("pushFull", pushFull, 1'b1);
    checkCount("pushSlots", pushSlots, '0);
    repeat (10) @(posedge popClk);
    checkCount("popItems", popItems, DepthC);

    popWords(Depth, 1'b0);
    checkDrained();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(WatchNs);
    $display("Watchdog expired after %0d ns before the tests completed", WatchNs);
    stopOnError();
  end

endmodule

//--- vlog.f
+incdir+common
common/cdcFifoPkg.sv
common/fifoRamIf.sv
cdcFifo/grayPtrSync.sv
cdcFifo/pushCtrl.sv
cdcFifo/popCtrl.sv
cdcFifo/flopRam.sv
cdcFifo/cdcFifo.sv
tests/cdcFifoTb.sv
